// File: hw/exec_pkg.sv
package exec_pkg;

    // Datapath widths
    localparam int RW        = 16;
    localparam int REGNO     = 8;
    localparam int REGNO_LOG = 3;

    // Flag vector layout
    localparam int FLAG_CNT = 5;
    localparam int FLAG_C   = 0;
    localparam int FLAG_Z   = 1;
    localparam int FLAG_N   = 2;
    localparam int FLAG_O   = 3;
    localparam int FLAG_P   = 4;

    typedef logic [RW-1:0]        word_t;
    typedef logic [REGNO_LOG-1:0] reg_sel_t;
    typedef logic [REGNO-1:0]     reg_mask_t;
    typedef logic [FLAG_CNT-1:0]  flags_t;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SHL = 4'd5,
        ALU_SHR = 4'd6,
        ALU_MOV = 4'd7
    } alu_mode_t;

    // Jump condition codes whose top bit marks a jump instruction
    typedef logic [4:0] jump_code_t;
    localparam int JUMP_EN_BIT = 4;

    localparam jump_code_t JMP_UNCOND = 5'b10000;
    localparam jump_code_t JMP_CARRY  = 5'b10001;
    localparam jump_code_t JMP_EQUAL  = 5'b10010;
    localparam jump_code_t JMP_LT     = 5'b10011;
    localparam jump_code_t JMP_GT     = 5'b10100;
    localparam jump_code_t JMP_LE     = 5'b10101;
    localparam jump_code_t JMP_GE     = 5'b10110;
    localparam jump_code_t JMP_NE     = 5'b10111;
    localparam jump_code_t JMP_OVF    = 5'b11000;
    localparam jump_code_t JMP_PAR    = 5'b11001;
    localparam jump_code_t JMP_GTU    = 5'b11010;
    localparam jump_code_t JMP_GEU    = 5'b11011;
    localparam jump_code_t JMP_LEU    = 5'b11100;

    typedef enum logic [3:0] {
        SREG_PC        = 4'h0,
        SREG_PRIV_CTRL = 4'h1,
        SREG_IRQ_PC    = 4'h3,
        SREG_ALU_FLAGS = 4'h4,
        SREG_IRQ_FLAGS = 4'h5,
        SREG_SCRATCH   = 4'h6,
        SREG_CPUID     = 4'h7,
        SREG_COREID    = 4'h8
    } sreg_addr_t;

    // Immediate field read as an ALU operand or as a special-register address
    typedef union packed {
        word_t word;
        struct packed {
            logic [11:0] rsvd;
            sreg_addr_t  addr;
        } sreg;
    } imm_u;

    typedef struct packed {
        logic       pc_inc;
        logic       pc_ie;
        logic       r_bus_imm;
        alu_mode_t  alu_mode;
        logic       carry_en;
        logic       flags_ie;
        reg_sel_t   l_sel;
        reg_sel_t   r_sel;
        reg_mask_t  rf_ie;
        jump_code_t jump_code;
        logic       mem_access;
        logic       mem_we;
        logic       mem_width;
        logic [1:0] used_operands;
        logic       sreg_load;
        logic       sreg_store;
        logic       sreg_jal_over;
        logic       sreg_irt;
    } exec_ctrl_t;

    typedef struct packed {
        word_t     data;
        word_t     addr;
        reg_mask_t reg_ie;
        logic      mem_access;
        logic      mem_we;
        logic      mem_width;
    } mem_req_t;

    localparam word_t CPUID           = 16'hF032;
    localparam word_t PRIV_RESET      = 16'h0001;
    localparam int    PRIV_MODE_BIT   = 0;
    localparam int    PRIV_IRQ_EN_BIT = 2;

endpackage

// File: hw/exec_regfile.sv
`timescale 1ns/10ps

module exec_regfile (
    input  logic                i_clk,
    input  logic                i_rst,
    input  exec_pkg::reg_sel_t  i_l_sel,
    input  exec_pkg::reg_sel_t  i_r_sel,
    input  exec_pkg::reg_mask_t i_ie,
    input  exec_pkg::word_t     i_d,
    output exec_pkg::word_t     o_l,
    output exec_pkg::word_t     o_r
);
    import exec_pkg::*;

    word_t regs [REGNO];

    // Write-back may hit several registers at once
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < REGNO; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < REGNO; i++) begin
                if (i_ie[i]) begin
                    regs[i] <= i_d;
                end
            end
        end
    end

    // Asynchronous read ports
    assign o_l = regs[i_l_sel];
    assign o_r = regs[i_r_sel];

endmodule

// File: hw/exec_alu.sv
`timescale 1ns/10ps

module exec_alu (
    input  exec_pkg::word_t     i_l,
    input  exec_pkg::word_t     i_r,
    input  exec_pkg::alu_mode_t i_mode,
    input  logic                i_carry,
    output exec_pkg::word_t     o_out,
    output exec_pkg::flags_t    o_flags
);
    import exec_pkg::*;

    localparam int SHAMT_W = $clog2(RW);

    logic [RW:0] wide;
    logic        carry;
    logic        ovf;

    always_comb begin
        wide  = '0;
        o_out = '0;
        carry = 1'b0;
        ovf   = 1'b0;
        case (i_mode)
            ALU_ADD: begin
                wide  = {1'b0, i_l} + {1'b0, i_r} + {{RW{1'b0}}, i_carry};
                o_out = wide[RW-1:0];
                carry = wide[RW];
                ovf   = (i_l[RW-1] == i_r[RW-1]) && (o_out[RW-1] != i_l[RW-1]);
            end
            ALU_SUB: begin
                // Carry out is the borrow
                wide  = {1'b0, i_l} - {1'b0, i_r} - {{RW{1'b0}}, i_carry};
                o_out = wide[RW-1:0];
                carry = wide[RW];
                ovf   = (i_l[RW-1] != i_r[RW-1]) && (o_out[RW-1] != i_l[RW-1]);
            end
            ALU_AND: begin
                o_out = i_l & i_r;
            end
            ALU_OR: begin
                o_out = i_l | i_r;
            end
            ALU_XOR: begin
                o_out = i_l ^ i_r;
            end
            ALU_SHL: begin
                // Last bit shifted out lands in the carry
                wide  = {1'b0, i_l} << i_r[SHAMT_W-1:0];
                o_out = wide[RW-1:0];
                carry = wide[RW];
            end
            ALU_SHR: begin
                wide  = {i_l, 1'b0} >> i_r[SHAMT_W-1:0];
                o_out = wide[RW:1];
                carry = wide[0];
            end
            ALU_MOV: begin
                o_out = i_r;
            end
            default: begin
                o_out = '0;
            end
        endcase
    end

    always_comb begin
        o_flags         = '0;
        o_flags[FLAG_C] = carry;
        o_flags[FLAG_Z] = (o_out == '0);
        o_flags[FLAG_N] = o_out[RW-1];
        o_flags[FLAG_O] = ovf;
        // Set for an even count of ones
        o_flags[FLAG_P] = ~^o_out;
    end

endmodule

// File: hw/exec_branch.sv
`timescale 1ns/10ps

module exec_branch (
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  logic                 i_en,
    input  logic                 i_flags_ie,
    input  logic                 i_sreg_flags_ie,
    input  exec_pkg::flags_t     i_flags_d,
    input  exec_pkg::word_t      i_sreg_d,
    input  exec_pkg::jump_code_t i_code,
    input  logic                 i_predict,
    output logic                 o_taken,
    output logic                 o_jump_valid,
    output logic                 o_mispredict,
    output exec_pkg::flags_t     o_flags
);
    import exec_pkg::*;

    // A store to the flags register wins over the ALU update
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_flags <= '0;
        end else if (i_en && i_sreg_flags_ie) begin
            o_flags <= i_sreg_d[FLAG_CNT-1:0];
        end else if (i_en && i_flags_ie) begin
            o_flags <= i_flags_d;
        end
    end

    always_comb begin
        case (i_code)
            JMP_UNCOND: o_taken = 1'b1;
            JMP_CARRY:  o_taken = o_flags[FLAG_C];
            JMP_EQUAL:  o_taken = o_flags[FLAG_Z];
            JMP_LT:     o_taken = o_flags[FLAG_N];
            JMP_GT:     o_taken = ~(o_flags[FLAG_N] | o_flags[FLAG_Z]);
            JMP_LE:     o_taken = o_flags[FLAG_N] | o_flags[FLAG_Z];
            JMP_GE:     o_taken = ~o_flags[FLAG_N];
            JMP_NE:     o_taken = ~o_flags[FLAG_Z];
            JMP_OVF:    o_taken = o_flags[FLAG_O];
            JMP_PAR:    o_taken = o_flags[FLAG_P];
            JMP_GTU:    o_taken = ~(o_flags[FLAG_C] | o_flags[FLAG_Z]);
            JMP_GEU:    o_taken = ~o_flags[FLAG_C];
            JMP_LEU:    o_taken = o_flags[FLAG_C] | o_flags[FLAG_Z];
            default:    o_taken = 1'b0;
        endcase
    end

    assign o_jump_valid = i_code[JUMP_EN_BIT];
    // Fetch guessed the other way, so everything behind this jump is wrong
    assign o_mispredict = o_jump_valid & (o_taken ^ i_predict);

endmodule

// File: hw/exec_pc.sv
`timescale 1ns/10ps

module exec_pc #(
    parameter exec_pkg::word_t INT_VEC = 16'h0010
) (
    input  logic            i_clk,
    input  logic            i_rst,
    input  logic            i_inc,
    input  logic            i_load,
    input  logic            i_irq,
    input  exec_pkg::word_t i_d,
    output exec_pkg::word_t o_pc
);
    import exec_pkg::*;

    // Interrupt beats load, load beats increment
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_pc <= '0;
        end else if (i_irq) begin
            o_pc <= INT_VEC;
        end else if (i_load) begin
            o_pc <= i_d;
        end else if (i_inc) begin
            o_pc <= o_pc + word_t'(1);
        end
    end

endmodule

// File: hw/exec_sregs.sv
`timescale 1ns/10ps

module exec_sregs #(
    parameter int CORENO = 0
) (
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  logic                 i_en,
    input  logic                 i_irq,
    input  exec_pkg::imm_u       i_imm,
    input  exec_pkg::exec_ctrl_t i_ctrl,
    input  exec_pkg::word_t      i_sreg_in,
    input  exec_pkg::word_t      i_pc,
    input  exec_pkg::word_t      i_flags_word,
    output exec_pkg::word_t      o_sreg_out,
    output exec_pkg::word_t      o_irq_pc,
    output logic                 o_irq_taken,
    output logic                 o_pc_write,
    output logic                 o_flags_store,
    output logic                 o_irq_en
);
    import exec_pkg::*;

    word_t      priv_ctrl;
    word_t      irq_pc;
    word_t      scratch;
    logic       irq_flag;
    sreg_addr_t sel;
    logic       store;
    logic       priv_mode;

    assign sel       = i_imm.sreg.addr;
    assign store     = i_ctrl.sreg_store & i_en;
    assign priv_mode = priv_ctrl[PRIV_MODE_BIT];

    assign o_irq_en    = priv_ctrl[PRIV_IRQ_EN_BIT];
    assign o_irq_taken = i_irq & o_irq_en;
    assign o_irq_pc    = irq_pc;

    // Strobes for the PC and the flag register that the caller qualifies
    assign o_pc_write    = (i_ctrl.sreg_store && sel == SREG_PC) || i_ctrl.sreg_irt;
    assign o_flags_store = i_ctrl.sreg_store && sel == SREG_ALU_FLAGS;

    // Entry forces privileged mode with interrupts off
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            priv_ctrl <= PRIV_RESET;
        end else if (o_irq_taken) begin
            priv_ctrl <= PRIV_RESET;
        end else if (i_en && i_ctrl.sreg_irt) begin
            priv_ctrl <= priv_ctrl | (word_t'(1) << PRIV_IRQ_EN_BIT);
        end else if (store && sel == SREG_PRIV_CTRL && priv_mode) begin
            priv_ctrl <= i_sreg_in;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            irq_flag <= 1'b0;
        end else if (o_irq_taken) begin
            irq_flag <= i_irq;
        end
    end

    // Return address of the interrupted instruction
    always_ff @(posedge i_clk) begin
        if (o_irq_taken) begin
            irq_pc <= i_pc;
        end else if (store && sel == SREG_IRQ_PC) begin
            irq_pc <= i_sreg_in;
        end
    end

    always_ff @(posedge i_clk) begin
        if (store && sel == SREG_SCRATCH) begin
            scratch <= i_sreg_in;
        end
    end

    always_comb begin
        case (sel)
            SREG_PC:        o_sreg_out = i_pc;
            SREG_PRIV_CTRL: o_sreg_out = priv_ctrl;
            SREG_IRQ_PC:    o_sreg_out = irq_pc;
            SREG_ALU_FLAGS: o_sreg_out = i_flags_word;
            SREG_IRQ_FLAGS: o_sreg_out = {{(RW-1){1'b0}}, irq_flag};
            SREG_SCRATCH:   o_sreg_out = scratch;
            SREG_CPUID:     o_sreg_out = CPUID;
            SREG_COREID:    o_sreg_out = word_t'(CORENO);
            default:        o_sreg_out = '0;
        endcase
        // Link and return override the addressed register
        if (i_ctrl.sreg_jal_over) begin
            o_sreg_out = i_pc;
        end
        if (i_ctrl.sreg_irt) begin
            o_sreg_out = irq_pc;
        end
    end

endmodule

// File: hw/exec_stage.sv
`timescale 1ns/10ps

module exec_stage #(
    parameter int              CORENO  = 0,
    parameter exec_pkg::word_t INT_VEC = 16'h0010
) (
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  logic                 i_submit,
    input  exec_pkg::exec_ctrl_t i_ctrl,
    input  exec_pkg::imm_u       i_imm,
    input  logic                 i_jmp_predict,
    input  logic                 i_next_ready,
    input  logic                 i_flush,
    input  exec_pkg::reg_mask_t  i_reg_ie,
    input  exec_pkg::word_t      i_reg_data,
    input  logic                 i_irq,
    output logic                 o_ready,
    output logic                 o_submit,
    output exec_pkg::mem_req_t   o_req,
    output logic                 o_flush,
    output logic                 o_pc_update,
    output exec_pkg::word_t      o_exec_pc
);
    import exec_pkg::*;

    logic   hold_valid;
    logic   next_ready_d;
    logic   hazard;
    logic   invalidate;
    logic   in_valid;
    logic   instr_valid;
    logic   exec_submit;
    word_t  reg_l;
    word_t  reg_r;
    word_t  alu_r;
    word_t  alu_out;
    flags_t alu_flags;
    flags_t flags;
    word_t  flags_word;
    logic   jump_taken;
    logic   jump_valid;
    logic   mispredict;
    word_t  pc;
    word_t  pc_d;
    logic   pc_inc;
    logic   pc_load;
    word_t  sreg_out;
    word_t  irq_pc;
    logic   irq_taken;
    logic   pc_write;
    logic   flags_store;
    logic   irq_en;

    // RAW hazard against the request still in the next stage. The first cycle after
    // back-pressure clears is covered by the delayed ready
    assign hazard = ((i_ctrl.used_operands[0] & o_req.reg_ie[i_ctrl.l_sel])
                   | (i_ctrl.used_operands[1] & o_req.reg_ie[i_ctrl.r_sel]))
                  & (o_submit | ~next_ready_d);

    assign invalidate  = i_flush | irq_taken;
    assign in_valid    = i_submit & ~invalidate;
    assign instr_valid = in_valid | (hold_valid & ~i_submit & ~invalidate);
    assign exec_submit = instr_valid & i_next_ready & ~hazard;
    assign o_ready     = exec_submit | ~instr_valid;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            hold_valid <= 1'b0;
        end else if (invalidate || exec_submit) begin
            hold_valid <= 1'b0;
        end else if (in_valid) begin
            hold_valid <= 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            next_ready_d <= 1'b0;
        end else begin
            next_ready_d <= i_next_ready;
        end
    end

    exec_regfile u_regfile (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_l_sel (i_ctrl.l_sel),
        .i_r_sel (i_ctrl.r_sel),
        .i_ie    (i_reg_ie),
        .i_d     (i_reg_data),
        .o_l     (reg_l),
        .o_r     (reg_r)
    );

    assign alu_r = i_ctrl.r_bus_imm ? i_imm.word : reg_r;

    exec_alu u_alu (
        .i_l     (reg_l),
        .i_r     (alu_r),
        .i_mode  (i_ctrl.alu_mode),
        .i_carry (flags[FLAG_C] & i_ctrl.carry_en),
        .o_out   (alu_out),
        .o_flags (alu_flags)
    );

    exec_branch u_branch (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_en            (exec_submit),
        .i_flags_ie      (i_ctrl.flags_ie),
        .i_sreg_flags_ie (flags_store),
        .i_flags_d       (alu_flags),
        .i_sreg_d        (reg_r),
        .i_code          (i_ctrl.jump_code),
        .i_predict       (i_jmp_predict),
        .o_taken         (jump_taken),
        .o_jump_valid    (jump_valid),
        .o_mispredict    (mispredict),
        .o_flags         (flags)
    );

    // Untaken jumps fall through to the next instruction
    assign pc_inc  = (i_ctrl.pc_inc | (jump_valid & ~jump_taken)) & exec_submit;
    assign pc_load = (i_ctrl.pc_ie | (jump_valid & jump_taken) | pc_write) & exec_submit;
    assign pc_d    = i_ctrl.sreg_irt   ? irq_pc :
                     i_ctrl.sreg_store ? reg_r  : alu_out;

    exec_pc #(.INT_VEC(INT_VEC)) u_pc (
        .i_clk  (i_clk),
        .i_rst  (i_rst),
        .i_inc  (pc_inc),
        .i_load (pc_load),
        .i_irq  (irq_taken),
        .i_d    (pc_d),
        .o_pc   (pc)
    );

    assign flags_word = {{(RW-FLAG_CNT){1'b0}}, flags};

    exec_sregs #(.CORENO(CORENO)) u_sregs (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_en          (exec_submit),
        .i_irq         (i_irq & irq_en),
        .i_imm         (i_imm),
        .i_ctrl        (i_ctrl),
        .i_sreg_in     (reg_r),
        .i_pc          (pc),
        .i_flags_word  (flags_word),
        .o_sreg_out    (sreg_out),
        .o_irq_pc      (irq_pc),
        .o_irq_taken   (irq_taken),
        .o_pc_write    (pc_write),
        .o_flags_store (flags_store),
        .o_irq_en      (irq_en)
    );

    assign o_pc_update = exec_submit;
    assign o_exec_pc   = pc;

    // Everything fetched after a redirect is stale
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_flush <= 1'b0;
        end else begin
            o_flush <= ((mispredict | pc_write) & exec_submit) | irq_taken;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_submit <= 1'b0;
        end else begin
            o_submit <= exec_submit;
        end
    end

    always_ff @(posedge i_clk) begin
        if (exec_submit) begin
            o_req.addr       <= alu_out;
            o_req.reg_ie     <= i_ctrl.rf_ie;
            o_req.mem_access <= i_ctrl.mem_access;
            o_req.mem_we     <= i_ctrl.mem_we;
            o_req.mem_width  <= i_ctrl.mem_width;
            if (i_ctrl.mem_access) begin
                o_req.data <= reg_r;
            end else if (i_ctrl.sreg_load) begin
                o_req.data <= sreg_out;
            end else if (i_ctrl.sreg_jal_over) begin
                // Link past the jump that follows
                o_req.data <= sreg_out + word_t'(1);
            end else begin
                o_req.data <= alu_out;
            end
        end
    end

endmodule

// File: dv/exec_tb_model.svh
`ifndef EXEC_TB_MODEL_SVH
`define EXEC_TB_MODEL_SVH

// ALU result as the instruction set defines it
function automatic word_t result_of(word_t l, word_t r, alu_mode_t mode, logic cin);
    int amt;
    amt = r[3:0];
    case (mode)
        ALU_ADD: return l + r + word_t'(cin);
        ALU_SUB: return l - r - word_t'(cin);
        ALU_AND: return l & r;
        ALU_OR:  return l | r;
        ALU_XOR: return l ^ r;
        ALU_SHL: return l << amt;
        ALU_SHR: return l >> amt;
        ALU_MOV: return r;
        default: return '0;
    endcase
endfunction

// Flags from integer arithmetic where carry is the borrow for sub
function automatic flags_t flags_of(word_t l, word_t r, alu_mode_t mode, logic cin);
    int     sl;
    int     sr;
    int     ci;
    int     s;
    int     amt;
    int     ones;
    word_t  res;
    flags_t f;
    res  = result_of(l, r, mode, cin);
    sl   = $signed(l);
    sr   = $signed(r);
    ci   = cin;
    amt  = r[3:0];
    ones = 0;
    f    = '0;
    case (mode)
        ALU_ADD: begin
            f[FLAG_C] = (int'(l) + int'(r) + ci) > 65535;
            s = sl + sr + ci;
            f[FLAG_O] = (s > 32767) || (s < -32768);
        end
        ALU_SUB: begin
            f[FLAG_C] = (int'(l) - int'(r) - ci) < 0;
            s = sl - sr - ci;
            f[FLAG_O] = (s > 32767) || (s < -32768);
        end
        ALU_SHL: f[FLAG_C] = (amt > 0) ? l[16-amt] : 1'b0;
        ALU_SHR: f[FLAG_C] = (amt > 0) ? l[amt-1] : 1'b0;
        default: f[FLAG_C] = 1'b0;
    endcase
    for (int i = 0; i < 16; i++) begin
        ones += res[i];
    end
    f[FLAG_Z] = (res == 16'h0000);
    f[FLAG_N] = res[15];
    f[FLAG_P] = (ones % 2) == 0;
    return f;
endfunction

// Jump decision against stored flags
function automatic logic condition_holds(jump_code_t code, flags_t f);
    case (code)
        JMP_UNCOND: return 1'b1;
        JMP_CARRY:  return f[FLAG_C];
        JMP_EQUAL:  return f[FLAG_Z];
        JMP_LT:     return f[FLAG_N];
        JMP_GT:     return !f[FLAG_N] && !f[FLAG_Z];
        JMP_LE:     return f[FLAG_N] || f[FLAG_Z];
        JMP_GE:     return !f[FLAG_N];
        JMP_NE:     return !f[FLAG_Z];
        JMP_OVF:    return f[FLAG_O];
        JMP_PAR:    return f[FLAG_P];
        JMP_GTU:    return !f[FLAG_C] && !f[FLAG_Z];
        JMP_GEU:    return !f[FLAG_C];
        JMP_LEU:    return f[FLAG_C] || f[FLAG_Z];
        default:    return 1'b0;
    endcase
endfunction

function automatic word_t special_reg_value(sreg_addr_t a, word_t pc, flags_t f, word_t priv,
                                            word_t irq_pc, word_t scratch, int coreno);
    case (a)
        SREG_PC:        return pc;
        SREG_PRIV_CTRL: return priv;
        SREG_IRQ_PC:    return irq_pc;
        SREG_ALU_FLAGS: return word_t'(f);
        SREG_SCRATCH:   return scratch;
        SREG_CPUID:     return 16'hF032;
        SREG_COREID:    return word_t'(coreno);
        default:        return '0;
    endcase
endfunction

`endif

// File: dv/exec_tb.sv
`timescale 1ns/10ps

module exec_tb;
    import exec_pkg::*;

    `include "exec_tb_model.svh"

    localparam int CORE_ID    = 3;
    localparam int WAIT_LIMIT = 200;

    logic       i_clk;
    logic       i_rst;
    logic       i_submit;
    exec_ctrl_t i_ctrl;
    imm_u       i_imm;
    logic       i_jmp_predict;
    logic       i_next_ready;
    logic       i_flush;
    reg_mask_t  i_reg_ie;
    word_t      i_reg_data;
    logic       i_irq;
    logic       o_ready;
    logic       o_submit;
    mem_req_t   o_req;
    logic       o_flush;
    logic       o_pc_update;
    word_t      o_exec_pc;

    int       seed = 32'h88fb86a7;
    int       mismatch_cnt = 0;
    int       fail_cnt = 0;
    logic     bp_on = 1'b0;
    mem_req_t expect_q[$];
    word_t    sh_regs[8];
    flags_t   sh_flags = '0;
    word_t    sh_pc = '0;
    word_t    sh_priv = 16'h0001;
    word_t    sh_irq_pc = '0;
    word_t    sh_scratch = '0;

    exec_stage #(.CORENO(CORE_ID), .INT_VEC(16'h0010)) DUT (.*);

    initial begin
        i_clk = 1'b0;
        forever begin
            #20 i_clk = ~i_clk;
        end
    end

    task automatic check_word(string what, word_t got, word_t exp);
        assert (got === exp) else begin
            mismatch_cnt++;
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Write-back of the forwarded request and its comparison
    initial begin
        mem_req_t e;
        forever begin
            @(negedge i_clk);
            if (o_submit === 1'b1) begin
                i_reg_ie   = o_req.reg_ie;
                i_reg_data = o_req.data;
                if (expect_q.size() == 0) begin
                    fail_cnt++;
                    $display("Error at %0t: o_submit with no instruction pending", $time);
                end else begin
                    e = expect_q.pop_front();
                    check_word("o_req.data", o_req.data, e.data);
                    check_word("o_req.addr", o_req.addr, e.addr);
                    assert (o_req.reg_ie === e.reg_ie && o_req.mem_access === e.mem_access
                            && o_req.mem_we === e.mem_we && o_req.mem_width === e.mem_width)
                    else begin
                        mismatch_cnt++;
                        $display("MISMATCH at %0t: o_req mask or memory controls wrong", $time);
                    end
                end
            end else begin
                i_reg_ie   = '0;
                i_reg_data = '0;
            end
        end
    end

    // Back-pressure from the next stage
    initial begin
        forever begin
            @(negedge i_clk);
            if (bp_on) begin
                i_next_ready = ($random(seed) & 3) != 0;
            end
        end
    end

    function automatic exec_ctrl_t default_ctrl();
        exec_ctrl_t c;
        c = '0;
        c.pc_inc        = 1'b1;
        c.used_operands = 2'b11;
        return c;
    endfunction

    task automatic issue(input exec_ctrl_t c, input imm_u imm, input logic pred);
        int       waited;
        word_t    l;
        word_t    r;
        word_t    reg_r;
        word_t    res;
        logic     cin;
        logic     taken;
        logic     exp_flush;
        mem_req_t e;
        i_ctrl        = c;
        i_imm         = imm;
        i_jmp_predict = pred;
        i_submit      = 1'b1;
        #1;
        waited = 0;
        while (o_ready !== 1'b1) begin
            // A stalled instruction must not move the PC
            check_word("o_pc_update", word_t'(o_pc_update), word_t'(1'b0));
            @(negedge i_clk);
            #1;
            waited++;
            if (waited > WAIT_LIMIT) begin
                fail_cnt++;
                $display("Error at %0t: instruction was never accepted", $time);
                i_submit = 1'b0;
                return;
            end
        end
        check_word("o_pc_update", word_t'(o_pc_update), word_t'(1'b1));
        reg_r = sh_regs[c.r_sel];
        l     = sh_regs[c.l_sel];
        r     = c.r_bus_imm ? imm.word : reg_r;
        cin   = c.carry_en & sh_flags[FLAG_C];
        res   = result_of(l, r, c.alu_mode, cin);
        e.addr       = res;
        e.reg_ie     = c.rf_ie;
        e.mem_access = c.mem_access;
        e.mem_we     = c.mem_we;
        e.mem_width  = c.mem_width;
        if (c.mem_access) begin
            e.data = reg_r;
        end else if (c.sreg_load) begin
            e.data = special_reg_value(imm.sreg.addr, sh_pc, sh_flags, sh_priv, sh_irq_pc,
                                       sh_scratch, CORE_ID);
        end else if (c.sreg_jal_over) begin
            e.data = sh_pc + 16'd1;
        end else begin
            e.data = res;
        end
        expect_q.push_back(e);
        exp_flush = 1'b0;
        if (c.jump_code[JUMP_EN_BIT]) begin
            taken     = condition_holds(c.jump_code, sh_flags);
            exp_flush = taken != pred;
            sh_pc     = taken ? res : sh_pc + 16'd1;
        end else if (c.sreg_irt) begin
            sh_pc     = sh_irq_pc;
            sh_priv   = sh_priv | 16'h0004;
            exp_flush = 1'b1;
        end else if (c.sreg_store && imm.sreg.addr == SREG_PC) begin
            sh_pc     = reg_r;
            exp_flush = 1'b1;
        end else if (c.pc_ie) begin
            sh_pc = res;
        end else if (c.pc_inc) begin
            sh_pc = sh_pc + 16'd1;
        end
        if (c.sreg_store && imm.sreg.addr == SREG_ALU_FLAGS) begin
            sh_flags = reg_r[4:0];
        end else if (c.flags_ie) begin
            sh_flags = flags_of(l, r, c.alu_mode, cin);
        end
        if (c.sreg_store && imm.sreg.addr == SREG_SCRATCH) sh_scratch = reg_r;
        if (c.sreg_store && imm.sreg.addr == SREG_IRQ_PC) sh_irq_pc = reg_r;
        if (c.sreg_store && imm.sreg.addr == SREG_PRIV_CTRL && sh_priv[0]) sh_priv = reg_r;
        for (int i = 0; i < 8; i++) begin
            if (c.rf_ie[i]) sh_regs[i] = e.data;
        end
        @(posedge i_clk);
        @(negedge i_clk);
        i_submit = 1'b0;
        check_word("o_flush", word_t'(o_flush), word_t'(exp_flush));
        check_word("o_exec_pc", o_exec_pc, sh_pc);
    endtask

    task automatic alu_op(alu_mode_t mode, reg_sel_t ls, reg_sel_t rs, reg_sel_t dst,
                          logic use_imm, word_t imm_val);
        exec_ctrl_t c;
        imm_u       imm;
        c           = default_ctrl();
        c.alu_mode  = mode;
        c.l_sel     = ls;
        c.r_sel     = rs;
        c.r_bus_imm = use_imm;
        c.carry_en  = $random(seed);
        c.flags_ie  = 1'b1;
        c.rf_ie     = reg_mask_t'(1) << dst;
        imm.word    = imm_val;
        issue(c, imm, 1'b0);
    endtask

    task automatic sreg_op(sreg_addr_t a, logic load, logic store, reg_sel_t rs,
                           reg_sel_t dst);
        exec_ctrl_t c;
        imm_u       imm;
        c            = default_ctrl();
        c.alu_mode   = ALU_MOV;
        c.r_sel      = rs;
        c.sreg_load  = load;
        c.sreg_store = store;
        c.rf_ie      = load ? reg_mask_t'(1) << dst : '0;
        imm.word     = '0;
        imm.sreg.addr = a;
        issue(c, imm, 1'b0);
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (expect_q.size() != 0) begin
            @(negedge i_clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                fail_cnt++;
                $display("Error at %0t: %0d results never came out", $time, expect_q.size());
                return;
            end
        end
    endtask

    initial begin
        exec_ctrl_t c;
        imm_u       imm;
        word_t      saved_pc;
        int         waited;
        jump_code_t codes[13];
        codes = '{JMP_UNCOND, JMP_CARRY, JMP_EQUAL, JMP_LT, JMP_GT, JMP_LE, JMP_GE,
                  JMP_NE, JMP_OVF, JMP_PAR, JMP_GTU, JMP_GEU, JMP_LEU};
        for (int i = 0; i < 8; i++) sh_regs[i] = '0;
        i_rst = 1'b1;
        i_submit = 1'b0;
        i_ctrl = '0;
        i_imm = '0;
        i_jmp_predict = 1'b0;
        i_next_ready = 1'b1;
        i_flush = 1'b0;
        i_reg_ie = '0;
        i_reg_data = '0;
        i_irq = 1'b0;
        repeat (3) @(posedge i_clk);
        @(negedge i_clk);
        i_rst = 1'b0;
        repeat (2) @(negedge i_clk);

        // Random ALU work on register and immediate operands
        for (int n = 0; n < 24; n++) begin
            alu_op(alu_mode_t'($random(seed) & 7), $random(seed), $random(seed),
                   $random(seed), $random(seed), $random(seed));
        end

        // Compare, then every jump condition
        for (int n = 0; n < 13; n++) begin
            c = default_ctrl();
            c.alu_mode = ALU_SUB;
            c.l_sel    = $random(seed);
            c.r_sel    = $random(seed);
            c.flags_ie = 1'b1;
            imm.word   = '0;
            issue(c, imm, 1'b0);
            c = default_ctrl();
            c.pc_inc    = 1'b0;
            c.r_bus_imm = 1'b1;
            c.alu_mode  = ALU_MOV;
            c.jump_code = codes[n];
            imm.word    = $random(seed);
            issue(c, imm, $random(seed));
        end

        // Dependent chain under back-pressure
        bp_on = 1'b1;
        for (int n = 0; n < 30; n++) begin
            alu_op(alu_mode_t'({$random(seed)} % 5), reg_sel_t'(n), reg_sel_t'(n + 7),
                   reg_sel_t'(n + 1), $random(seed), $random(seed));
        end
        bp_on = 1'b0;
        @(negedge i_clk);
        i_next_ready = 1'b1;
        wait_drained();

        // Special registers
        alu_op(ALU_MOV, 0, 0, 2, 1'b1, $random(seed));
        sreg_op(SREG_SCRATCH, 1'b0, 1'b1, 2, 0);
        sreg_op(SREG_SCRATCH, 1'b1, 1'b0, 0, 3);
        sreg_op(SREG_CPUID, 1'b1, 1'b0, 0, 4);
        sreg_op(SREG_COREID, 1'b1, 1'b0, 0, 5);
        alu_op(ALU_SUB, 1, 6, 7, 1'b0, 0);
        sreg_op(SREG_ALU_FLAGS, 1'b1, 1'b0, 0, 6);
        c = default_ctrl();
        c.sreg_jal_over = 1'b1;
        c.rf_ie = 8'h01;
        imm.word = '0;
        issue(c, imm, 1'b0);

        // Interrupt entry and return
        alu_op(ALU_MOV, 0, 0, 1, 1'b1, 16'h0005);
        sreg_op(SREG_PRIV_CTRL, 1'b0, 1'b1, 1, 0);
        wait_drained();
        i_irq = 1'b1;
        waited = 0;
        saved_pc = sh_pc;
        @(negedge i_clk);
        while (o_flush !== 1'b1 && waited < WAIT_LIMIT) begin
            @(negedge i_clk);
            waited++;
        end
        i_irq = 1'b0;
        if (waited >= WAIT_LIMIT) begin
            fail_cnt++;
            $display("Error at %0t: interrupt never raised a flush", $time);
        end
        sh_pc = 16'h0010;
        sh_irq_pc = saved_pc;
        sh_priv = 16'h0001;
        check_word("o_exec_pc after interrupt", o_exec_pc, 16'h0010);
        sreg_op(SREG_IRQ_PC, 1'b1, 1'b0, 0, 2);
        c = default_ctrl();
        c.pc_inc = 1'b0;
        c.sreg_irt = 1'b1;
        issue(c, imm, 1'b0);

        // Memory requests
        for (int n = 0; n < 8; n++) begin
            c = default_ctrl();
            c.alu_mode   = ALU_ADD;
            c.l_sel      = $random(seed);
            c.r_sel      = $random(seed);
            c.mem_access = 1'b1;
            c.mem_we     = $random(seed);
            c.mem_width  = $random(seed);
            issue(c, imm, 1'b0);
        end
        wait_drained();

        $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: exec_core.f
hw/exec_pkg.sv
hw/exec_regfile.sv
hw/exec_alu.sv
hw/exec_branch.sv
hw/exec_pc.sv
hw/exec_sregs.sv
hw/exec_stage.sv
+incdir+dv
dv/exec_tb.sv
